//--- mdu.f
mdu_pkg.sv
mdu_hilo.sv
mdu_mul.sv
mdu_div.sv
mdu_ctrl.sv
mdu_top.sv
mdu_tb.sv

//--- mdu_tb.sv
`default_nettype none

module mdu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 20;
    localparam int rst_cycles = 16;
    localparam int max_stall  = 7;
    localparam int n_rows     = 25;
    localparam int watchdog_cycles = n_rows * (40 + max_stall) + rst_cycles;

    typedef struct packed {
        mdu_pkg::mdu_op_e op;
        logic [31:0]      src1;
        logic [31:0]      src2;
        logic             rnd;   // replace src1/src2 with lcg values
    } row_t;

    logic               clk;
    logic               rst;
    logic               req_valid;
    mdu_pkg::mdu_req_t  req;
    logic               req_ready;
    logic               resp_valid;
    mdu_pkg::mdu_resp_t resp;
    logic               resp_ready;

    logic [31:0] lcg_state = 32'h8dbea539;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    int          errors     = 0;
    int          accept_cnt = 0;
    int          resp_cnt   = 0;

    row_t rows [n_rows] = '{
        '{mdu_pkg::op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0},  // straight out of reset
        '{mdu_pkg::op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mult,  32'h8000_0000, 32'h8000_0000, 1'b0},
        '{mdu_pkg::op_multu, 32'hffff_ffff, 32'hffff_ffff, 1'b0},
        '{mdu_pkg::op_mult,  32'hffff_ffff, 32'h0000_0001, 1'b0},
        '{mdu_pkg::op_multu, 32'h0000_0000, 32'hffff_ffff, 1'b0},
        '{mdu_pkg::op_mult,  32'h8000_0000, 32'hffff_ffff, 1'b0},
        '{mdu_pkg::op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mult,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_multu, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_div,   32'hffff_fff9, 32'h0000_0002, 1'b0},  // -7 / 2
        '{mdu_pkg::op_div,   32'h0000_0007, 32'hffff_fffe, 1'b0},  // 7 / -2
        '{mdu_pkg::op_divu,  32'hffff_ffff, 32'h0000_0003, 1'b0},
        '{mdu_pkg::op_div,   32'h8000_0000, 32'hffff_ffff, 1'b0},
        '{mdu_pkg::op_div,   32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_divu,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_div,   32'h0000_3039, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_divu,  32'h8000_0001, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mthi,  32'hdead_beef, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mtlo,  32'h1357_9bdf, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{mdu_pkg::op_mthi,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_mtlo,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{mdu_pkg::op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b0}
    };

    mdu_top mdu_top_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // transfer counters on both interfaces
    always @(posedge clk) begin
        if (!rst && req_valid && req_ready)
            accept_cnt <= accept_cnt + 1;
        if (!rst && resp_valid && resp_ready)
            resp_cnt <= resp_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected hi/lo after one operation from the isa rules
    task automatic apply_model(input mdu_pkg::mdu_op_e op, input logic [31:0] a,
                               input logic [31:0] b);
        longint          sa;
        longint          sb;
        longint          sres;
        longint unsigned ures;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            mdu_pkg::op_mult: begin
                sres     = sa * sb;
                model_hi = sres[63:32];
                model_lo = sres[31:0];
            end
            mdu_pkg::op_multu: begin
                ures     = 64'(a) * 64'(b);
                model_hi = ures[63:32];
                model_lo = ures[31:0];
            end
            mdu_pkg::op_div, mdu_pkg::op_divu: begin
                if (b == 32'd0) begin
                    model_lo = '1;
                    model_hi = a;
                end else if (op == mdu_pkg::op_div) begin
                    sres     = sa / sb;  // truncates toward zero
                    model_lo = sres[31:0];
                    sres     = sa % sb;  // sign follows the dividend
                    model_hi = sres[31:0];
                end else begin
                    model_lo = a / b;
                    model_hi = a % b;
                end
            end
            mdu_pkg::op_mthi: model_hi = a;
            mdu_pkg::op_mtlo: model_lo = a;
            default: ;  // move-from leaves the pair alone
        endcase
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
        else begin
            $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic run_row(input row_t row);
        mdu_pkg::mdu_req_t r;
        logic [31:0]       rnd_bits;
        int                stall;
        r.op   = row.op;
        r.src1 = row.rnd ? lcg_next() : row.src1;
        r.src2 = row.rnd ? lcg_next() : row.src2;
        rnd_bits = lcg_next();
        stall    = int'(rnd_bits[31:29]);
        req_valid <= 1'b1;
        req       <= r;
        do begin
            @(posedge clk);
            check_value("resp_valid", 64'd0, 64'(resp_valid));  // no response before accept
        end while (!req_ready);
        req_valid <= 1'b0;
        apply_model(r.op, r.src1, r.src2);
        do @(posedge clk); while (!resp_valid);
        repeat (stall) begin
            @(posedge clk);
            check_value("resp_valid", 64'd1, 64'(resp_valid));
            check_value("req_ready", 64'd0, 64'(req_ready));
            check_value("resp", {model_hi, model_lo}, 64'(resp));
        end
        resp_ready <= 1'b1;
        @(posedge clk);  // handshake edge
        check_value("resp_valid", 64'd1, 64'(resp_valid));
        check_value("resp.hi", 64'(model_hi), 64'(resp.hi));
        check_value("resp.lo", 64'(model_lo), 64'(resp.lo));
        resp_ready <= 1'b0;
    endtask

    initial begin
        mdu_pkg::mdu_op_e op;
        int               errors_before;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        model_hi   = '0;
        model_lo   = '0;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("req_ready", 64'd1, 64'(req_ready));
        check_value("resp_valid", 64'd0, 64'(resp_valid));

        for (int i = 0; i < n_rows; i++) begin
            errors_before = errors;
            op = rows[i].op;
            run_row(rows[i]);
            $display("row %0d %s: %s", i, op.name(),
                     (errors == errors_before) ? "ok" : "mismatch");
        end

        @(posedge clk);  // let the counters settle
        assert (accept_cnt == resp_cnt && accept_cnt == n_rows)
        else begin
            $display("response count %0d does not match accepted count %0d",
                     resp_cnt, accept_cnt);
            errors++;
        end
        $display("%0d rows, %0d accepted, %0d responses, %0d errors",
                 n_rows, accept_cnt, resp_cnt, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired before all rows finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- mdu_top.sv
`default_nettype none

module mdu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  mdu_pkg::mdu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output mdu_pkg::mdu_resp_t resp,
    input  logic               resp_ready
);

    logic [mdu_pkg::data_w-1:0]   src1;
    logic [mdu_pkg::data_w-1:0]   src2;
    logic                         mul_start;
    logic                         mul_signed;
    logic [2*mdu_pkg::data_w-1:0] mul_prod;
    logic                         mul_done;
    logic                         div_start;
    logic                         div_signed;
    logic [mdu_pkg::data_w-1:0]   div_quot;
    logic [mdu_pkg::data_w-1:0]   div_rem;
    logic                         div_done;
    mdu_pkg::hilo_wr_t            hilo_wr;
    logic [mdu_pkg::data_w-1:0]   hi;
    logic [mdu_pkg::data_w-1:0]   lo;

    mdu_ctrl mdu_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .src1       (src1),
        .src2       (src2),
        .mul_start  (mul_start),
        .mul_signed (mul_signed),
        .mul_prod   (mul_prod),
        .mul_done   (mul_done),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_quot   (div_quot),
        .div_rem    (div_rem),
        .div_done   (div_done),
        .hilo_wr    (hilo_wr),
        .hi         (hi),
        .lo         (lo)
    );

    mdu_mul mdu_mul_i (
        .clk       (clk),
        .rst       (rst),
        .start     (mul_start),
        .is_signed (mul_signed),
        .a         (src1),
        .b         (src2),
        .prod      (mul_prod),
        .done      (mul_done)
    );

    mdu_div mdu_div_i (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .quot      (div_quot),
        .rem       (div_rem),
        .done      (div_done)
    );

    mdu_hilo mdu_hilo_i (
        .clk (clk),
        .rst (rst),
        .wr  (hilo_wr),
        .hi  (hi),
        .lo  (lo)
    );

endmodule

`default_nettype wire

//--- mdu_ctrl.sv
`default_nettype none

module mdu_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  mdu_pkg::mdu_req_t            req,
    output logic                         req_ready,
    output logic                         resp_valid,
    output mdu_pkg::mdu_resp_t           resp,
    input  logic                         resp_ready,
    output logic [mdu_pkg::data_w-1:0]   src1,
    output logic [mdu_pkg::data_w-1:0]   src2,
    output logic                         mul_start,
    output logic                         mul_signed,
    input  logic [2*mdu_pkg::data_w-1:0] mul_prod,
    input  logic                         mul_done,
    output logic                         div_start,
    output logic                         div_signed,
    input  logic [mdu_pkg::data_w-1:0]   div_quot,
    input  logic [mdu_pkg::data_w-1:0]   div_rem,
    input  logic                         div_done,
    output mdu_pkg::hilo_wr_t            hilo_wr,
    input  logic [mdu_pkg::data_w-1:0]   hi,
    input  logic [mdu_pkg::data_w-1:0]   lo
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_mul,
        st_wait_div,
        st_respond
    } state_e;

    state_e            state;
    mdu_pkg::mdu_req_t req_q;
    logic              accept;

    assign req_ready  = (state == st_idle);  // one operation in flight
    assign resp_valid = (state == st_respond);
    assign accept     = req_valid && req_ready;

    // operands for both units come from the captured request
    assign src1       = req_q.src1;
    assign src2       = req_q.src2;
    assign mul_signed = (req_q.op == mdu_pkg::op_mult);
    assign div_signed = (req_q.op == mdu_pkg::op_div);

    // hi/lo see no write while responding and hold the response
    assign resp = '{hi: hi, lo: lo};

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        case (req.op)
                            mdu_pkg::op_mult, mdu_pkg::op_multu: begin
                                state     <= st_wait_mul;
                                mul_start <= 1'b1;
                            end
                            mdu_pkg::op_div, mdu_pkg::op_divu: begin
                                state     <= st_wait_div;
                                div_start <= 1'b1;
                            end
                            default: state <= st_respond;  // moves finish at once
                        endcase
                    end
                end
                st_wait_mul: if (mul_done) state <= st_respond;
                st_wait_div: if (div_done) state <= st_respond;
                st_respond:  if (resp_ready) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    // move-to writes on the accept edge and results write on done
    always_comb begin
        hilo_wr = '0;
        case (state)
            st_idle: begin
                if (accept && req.op == mdu_pkg::op_mthi) begin
                    hilo_wr.we_hi = 1'b1;
                    hilo_wr.hi    = req.src1;
                end
                if (accept && req.op == mdu_pkg::op_mtlo) begin
                    hilo_wr.we_lo = 1'b1;
                    hilo_wr.lo    = req.src1;
                end
            end
            st_wait_mul: begin
                if (mul_done)
                    hilo_wr = '{we_hi: 1'b1, we_lo: 1'b1, hi: mul_prod[63:32], lo: mul_prod[31:0]};
            end
            st_wait_div: begin
                if (div_done)
                    hilo_wr = '{we_hi: 1'b1, we_lo: 1'b1, hi: div_rem, lo: div_quot};
            end
            default: hilo_wr = '0;
        endcase
    end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed under back-pressure");

    mul_done_in_wait: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> state == st_wait_mul)
        else $error("mul_done outside wait_mul");

    div_done_in_wait: assert property (@(posedge clk) disable iff (rst)
        div_done |-> state == st_wait_div)
        else $error("div_done outside wait_div");

endmodule

`default_nettype wire

//--- mdu_div.sv
`default_nettype none

module mdu_div (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       is_signed,
    input  logic [mdu_pkg::data_w-1:0] dividend,
    input  logic [mdu_pkg::data_w-1:0] divisor,
    output logic [mdu_pkg::data_w-1:0] quot,
    output logic [mdu_pkg::data_w-1:0] rem,
    output logic                       done
);

    logic                           busy;
    logic                           fix;      // sign-fix cycle
    logic [mdu_pkg::div_cnt_w-1:0]  cnt;
    logic [2*mdu_pkg::data_w-1:0]   acc;      // {partial remainder, quotient}
    logic [mdu_pkg::data_w-1:0]     dvs;
    logic [mdu_pkg::data_w-1:0]     dvd;
    logic                           neg_q;
    logic                           neg_r;
    logic                           by_zero;
    logic [mdu_pkg::data_w-1:0]     a_abs;
    logic [mdu_pkg::data_w-1:0]     b_abs;

    // one restoring step shifts in the next dividend bit and subtracts if it fits
    function automatic logic [2*mdu_pkg::data_w-1:0] div_step(
        input logic [2*mdu_pkg::data_w-1:0] cur,
        input logic [mdu_pkg::data_w-1:0]   d
    );
        logic [mdu_pkg::data_w:0] part;
        logic [mdu_pkg::data_w:0] diff;
        part = cur[2*mdu_pkg::data_w-1:mdu_pkg::data_w-1];
        diff = part - {1'b0, d};
        if (diff[mdu_pkg::data_w])
            return {part[mdu_pkg::data_w-1:0], cur[mdu_pkg::data_w-2:0], 1'b0};
        return {diff[mdu_pkg::data_w-1:0], cur[mdu_pkg::data_w-2:0], 1'b1};
    endfunction

    assign a_abs = (is_signed && dividend[mdu_pkg::data_w-1]) ? -dividend : dividend;
    assign b_abs = (is_signed && divisor[mdu_pkg::data_w-1])  ? -divisor  : divisor;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            fix  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= fix;
            if (start) begin
                busy <= 1'b1;
            end else if (fix) begin
                busy <= 1'b0;
                fix  <= 1'b0;
            end else if (busy && cnt == mdu_pkg::div_last) begin
                fix <= 1'b1;  // last step runs on this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // first step is taken while loading
            acc     <= div_step({{mdu_pkg::data_w{1'b0}}, a_abs}, b_abs);
            dvs     <= b_abs;
            dvd     <= dividend;
            neg_q   <= is_signed && (dividend[mdu_pkg::data_w-1] != divisor[mdu_pkg::data_w-1]);
            neg_r   <= is_signed && dividend[mdu_pkg::data_w-1];
            by_zero <= (divisor == '0);
            cnt     <= 'd1;
        end else if (busy && !fix) begin
            acc <= div_step(acc, dvs);
            cnt <= cnt + 1'b1;
        end
        if (fix) begin
            if (by_zero) begin
                quot <= '1;
                rem  <= dvd;
            end else begin
                quot <= neg_q ? -acc[mdu_pkg::data_w-1:0] : acc[mdu_pkg::data_w-1:0];
                rem  <= neg_r ? -acc[2*mdu_pkg::data_w-1:mdu_pkg::data_w]
                              : acc[2*mdu_pkg::data_w-1:mdu_pkg::data_w];
            end
        end
    end

    no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

//--- mdu_mul.sv
`default_nettype none

module mdu_mul (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         is_signed,
    input  logic [mdu_pkg::data_w-1:0]   a,
    input  logic [mdu_pkg::data_w-1:0]   b,
    output logic [2*mdu_pkg::data_w-1:0] prod,
    output logic                         done
);

    logic                                stage1;  // operands valid in stage one
    logic signed [mdu_pkg::data_w:0]     a_ext;
    logic signed [mdu_pkg::data_w:0]     b_ext;
    logic signed [2*mdu_pkg::data_w+1:0] full;

    // one extra bit makes a single signed multiply cover both flavours
    assign full = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1 <= 1'b0;
            done   <= 1'b0;
        end else begin
            stage1 <= start;
            done   <= stage1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_ext <= {is_signed && a[mdu_pkg::data_w-1], a};
            b_ext <= {is_signed && b[mdu_pkg::data_w-1], b};
        end
        if (stage1)
            prod <= full[2*mdu_pkg::data_w-1:0];
    end

endmodule

`default_nettype wire

//--- mdu_hilo.sv
`default_nettype none

module mdu_hilo (
    input  logic                       clk,
    input  logic                       rst,
    input  mdu_pkg::hilo_wr_t          wr,
    output logic [mdu_pkg::data_w-1:0] hi,
    output logic [mdu_pkg::data_w-1:0] lo
);

    logic [mdu_pkg::data_w-1:0] hi_q;
    logic [mdu_pkg::data_w-1:0] lo_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wr.we_hi)
                hi_q <= wr.hi;
            if (wr.we_lo)  // mthi leaves lo alone
                lo_q <= wr.lo;
        end
    end

    assign hi = hi_q;
    assign lo = lo_q;

endmodule

`default_nettype wire

//--- mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    localparam int data_w    = 32;
    localparam int div_steps = 32;
    localparam int div_cnt_w = $clog2(div_steps);

    // counter value on the edge that runs the last shift-subtract step
    localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(div_steps - 1);

    typedef enum logic [2:0] {
        op_mult  = 3'd0,
        op_multu = 3'd1,
        op_div   = 3'd2,
        op_divu  = 3'd3,
        op_mfhi  = 3'd4,
        op_mflo  = 3'd5,
        op_mthi  = 3'd6,
        op_mtlo  = 3'd7
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e           op;
        logic [data_w-1:0] src1;  // rs holds the dividend or the value to move
        logic [data_w-1:0] src2;  // rt holds the divisor
    } mdu_req_t;

    typedef struct packed {
        logic [data_w-1:0] hi;
        logic [data_w-1:0] lo;
    } mdu_resp_t;

    // write port of the hi/lo pair with its own enable per half
    typedef struct packed {
        logic              we_hi;
        logic              we_lo;
        logic [data_w-1:0] hi;
        logic [data_w-1:0] lo;
    } hilo_wr_t;

endpackage

`default_nettype wire
